//--- Makefile
TOP = htable_cuckoo_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module $(TOP) -j 0

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- rtl/htable_bank.sv
`include "htable_settings.svh"
`default_nettype none

module htable_bank (
    input  logic                   clk,
    input  logic                   reset,
    input  htable_pkg::hash_t      lookup_addr,
    output htable_pkg::tbl_entry_t lookup_data,
    htable_bank_intf.bank          ctrl,
    output logic                   init_done
);
    import htable_pkg::*;

    localparam int DEPTH = 1 << `HTABLE_ADDR_WIDTH;

    tbl_entry_t mem [DEPTH];
    hash_t      init_addr;

    // --------------------
    // Init sweep
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_addr <= init_addr + hash_t'(1);
            if (init_addr == '1) begin
                init_done <= 1'b1;
            end
        end
    end

    // --------------------
    // Storage
    // --------------------
    // Sweep owns the write port until every slot is cleared
    always_ff @(posedge clk) begin
        if (!init_done && !reset) begin
            mem[init_addr] <= '0;
        end else if (ctrl.wr_en) begin
            mem[ctrl.wr_addr] <= ctrl.wr_data;
        end
    end

    // Both read ports return old data on a same-cycle write
    always_ff @(posedge clk) begin
        lookup_data <= mem[lookup_addr];
        if (ctrl.rd_en) begin
            ctrl.rd_data <= mem[ctrl.rd_addr];
        end
    end

    // Controller must wait for the sweep before touching the table
    assert property (@(posedge clk) disable iff (reset) ctrl.wr_en |-> init_done)
        else $error("htable_bank: control write during init sweep");

endmodule : htable_bank

`default_nettype wire

//--- rtl/htable_bank_intf.sv
`default_nettype none

interface htable_bank_intf;
    import htable_pkg::*;

    // Read port, data returns one cycle after rd_en
    logic       rd_en;
    hash_t      rd_addr;
    tbl_entry_t rd_data;

    // Write port, takes effect at the clock edge
    logic       wr_en;
    hash_t      wr_addr;
    tbl_entry_t wr_data;

    modport requester (
        output rd_en, rd_addr,
        input  rd_data,
        output wr_en, wr_addr, wr_data
    );

    modport bank (
        input  rd_en, rd_addr,
        output rd_data,
        input  wr_en, wr_addr, wr_data
    );

endinterface : htable_bank_intf

`default_nettype wire

//--- rtl/htable_cuckoo_core.sv
`default_nettype none

module htable_cuckoo_core (
    input  logic                       clk,
    input  logic                       reset,
    output logic                       init_done,
    // Lookup path
    input  logic                       lookup_req,
    input  htable_pkg::key_t           lookup_key,
    output logic                       lookup_ack,
    output logic                       lookup_hit,
    output htable_pkg::value_t         lookup_value,
    // Insert path
    input  logic                       insert_req,
    input  htable_pkg::key_t           insert_key,
    input  htable_pkg::value_t         insert_value,
    output logic                       insert_ready,
    output logic                       insert_done,
    output htable_pkg::insert_status_t insert_status
);
    import htable_pkg::*;

    hash_t      lookup_hash0;
    hash_t      lookup_hash1;
    hash_t      ctrl_hash0;
    hash_t      ctrl_hash1;
    key_t       ctrl_key;
    tbl_entry_t bank0_data;
    tbl_entry_t bank1_data;
    logic       bank0_init_done;
    logic       bank1_init_done;
    logic       stash_valid;
    key_t       stash_key;
    value_t     stash_value;

    htable_bank_intf bank0_if ();
    htable_bank_intf bank1_if ();

    // --------------------
    // Hash
    // --------------------
    htable_hash hash_inst (
        .clk          (clk),
        .lookup_key   (lookup_key),
        .ctrl_key     (ctrl_key),
        .lookup_hash0 (lookup_hash0),
        .lookup_hash1 (lookup_hash1),
        .ctrl_hash0   (ctrl_hash0),
        .ctrl_hash1   (ctrl_hash1)
    );

    // --------------------
    // Table banks
    // --------------------
    htable_bank bank0_inst (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_hash0),
        .lookup_data (bank0_data),
        .ctrl        (bank0_if),
        .init_done   (bank0_init_done)
    );

    htable_bank bank1_inst (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_hash1),
        .lookup_data (bank1_data),
        .ctrl        (bank1_if),
        .init_done   (bank1_init_done)
    );

    // --------------------
    // Consumers
    // --------------------
    htable_lookup lookup_inst (
        .clk          (clk),
        .reset        (reset),
        .lookup_req   (lookup_req),
        .lookup_key   (lookup_key),
        .init_done    (init_done),
        .bank0_data   (bank0_data),
        .bank1_data   (bank1_data),
        .stash_valid  (stash_valid),
        .stash_key    (stash_key),
        .stash_value  (stash_value),
        .lookup_ack   (lookup_ack),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value)
    );

    htable_cuckoo_ctrl ctrl_inst (
        .clk             (clk),
        .reset           (reset),
        .bank0_init_done (bank0_init_done),
        .bank1_init_done (bank1_init_done),
        .init_done       (init_done),
        .insert_req      (insert_req),
        .insert_key      (insert_key),
        .insert_value    (insert_value),
        .insert_ready    (insert_ready),
        .insert_done     (insert_done),
        .insert_status   (insert_status),
        .ctrl_key        (ctrl_key),
        .ctrl_hash0      (ctrl_hash0),
        .ctrl_hash1      (ctrl_hash1),
        .bank0           (bank0_if),
        .bank1           (bank1_if),
        .stash_valid     (stash_valid),
        .stash_key       (stash_key),
        .stash_value     (stash_value)
    );

endmodule : htable_cuckoo_core

`default_nettype wire

//--- rtl/htable_cuckoo_ctrl.sv
`include "htable_settings.svh"
`default_nettype none

module htable_cuckoo_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       bank0_init_done,
    input  logic                       bank1_init_done,
    output logic                       init_done,
    input  logic                       insert_req,
    input  htable_pkg::key_t           insert_key,
    input  htable_pkg::value_t         insert_value,
    output logic                       insert_ready,
    output logic                       insert_done,
    output htable_pkg::insert_status_t insert_status,
    output htable_pkg::key_t           ctrl_key,
    input  htable_pkg::hash_t          ctrl_hash0,
    input  htable_pkg::hash_t          ctrl_hash1,
    htable_bank_intf.requester         bank0,
    htable_bank_intf.requester         bank1,
    output logic                       stash_valid,
    output htable_pkg::key_t           stash_key,
    output htable_pkg::value_t         stash_value
);
    import htable_pkg::*;

    localparam int KICK_WIDTH = $clog2(`HTABLE_MAX_KICKS + 1);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_READY,
        ST_HASH,
        ST_READ,
        ST_DECIDE,
        ST_DONE,
        ST_FULL
    } state_t;

    state_t                state;
    key_t                  carry_key;
    value_t                carry_value;
    tbl_entry_t            carry_entry;
    tbl_entry_t            entry0;
    tbl_entry_t            entry1;
    tbl_entry_t            victim;
    logic                  cur_tbl;
    logic                  first_step;
    logic [KICK_WIDTH-1:0] kick_cnt;
    logic                  match0;
    logic                  match1;
    logic                  stash_match;
    logic                  wr0_en;
    logic                  wr1_en;
    logic                  step_kick;
    logic                  step_stash;
    logic                  stash_update;
    insert_status_t        step_status;

    assign carry_entry = {1'b1, carry_key, carry_value};
    assign ctrl_key    = carry_key;
    assign entry0      = bank0.rd_data;
    assign entry1      = bank1.rd_data;
    assign victim      = cur_tbl ? entry1 : entry0;

    // --------------------
    // Bank access
    // --------------------
    // Hash of the carried key stays valid through READ and DECIDE
    assign bank0.rd_en   = (state == ST_READ);
    assign bank0.rd_addr = ctrl_hash0;
    assign bank0.wr_en   = wr0_en;
    assign bank0.wr_addr = ctrl_hash0;
    assign bank0.wr_data = carry_entry;

    assign bank1.rd_en   = (state == ST_READ);
    assign bank1.rd_addr = ctrl_hash1;
    assign bank1.wr_en   = wr1_en;
    assign bank1.wr_addr = ctrl_hash1;
    assign bank1.wr_data = carry_entry;

    // --------------------
    // Step decision
    // --------------------
    assign match0      = entry0.valid && (entry0.key == carry_key);
    assign match1      = entry1.valid && (entry1.key == carry_key);
    assign stash_match = stash_valid && (stash_key == carry_key);

    always_comb begin
        wr0_en       = 1'b0;
        wr1_en       = 1'b0;
        step_kick    = 1'b0;
        step_stash   = 1'b0;
        stash_update = 1'b0;
        step_status  = INSERT_ADDED;
        if (state == ST_DECIDE) begin
            if (first_step && stash_match) begin
                stash_update = 1'b1;
                step_status  = INSERT_UPDATED;
            end else if (match0) begin
                wr0_en      = 1'b1;
                step_status = INSERT_UPDATED;
            end else if (match1) begin
                wr1_en      = 1'b1;
                step_status = INSERT_UPDATED;
            end else if (!entry0.valid) begin
                wr0_en = 1'b1;
            end else if (!entry1.valid) begin
                wr1_en = 1'b1;
            end else if (kick_cnt == KICK_WIDTH'(`HTABLE_MAX_KICKS)) begin
                step_stash  = 1'b1;
                step_status = INSERT_STASHED;
            end else begin
                // Both slots taken, evict the occupant of the current table
                step_kick = 1'b1;
                wr0_en    = !cur_tbl;
                wr1_en    = cur_tbl;
            end
        end
    end

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_INIT;
            init_done    <= 1'b0;
            insert_ready <= 1'b0;
            insert_done  <= 1'b0;
            stash_valid  <= 1'b0;
            cur_tbl      <= 1'b0;
            first_step   <= 1'b0;
            kick_cnt     <= '0;
        end else begin
            insert_done <= 1'b0;
            case (state)
                ST_INIT: begin
                    if (bank0_init_done && bank1_init_done) begin
                        init_done    <= 1'b1;
                        insert_ready <= 1'b1;
                        state        <= ST_READY;
                    end
                end
                ST_READY: begin
                    if (insert_req) begin
                        insert_ready <= 1'b0;
                        cur_tbl      <= 1'b0;
                        first_step   <= 1'b1;
                        kick_cnt     <= '0;
                        state        <= ST_HASH;
                    end
                end
                ST_HASH:   state <= ST_READ;
                ST_READ:   state <= ST_DECIDE;
                ST_DECIDE: begin
                    if (step_kick) begin
                        cur_tbl    <= !cur_tbl;
                        first_step <= 1'b0;
                        kick_cnt   <= kick_cnt + KICK_WIDTH'(1);
                        state      <= ST_HASH;
                    end else begin
                        insert_done <= 1'b1;
                        state       <= ST_DONE;
                    end
                    if (step_stash) begin
                        stash_valid <= 1'b1;
                    end
                end
                ST_DONE: begin
                    if (stash_valid) begin
                        state <= ST_FULL;
                    end else begin
                        insert_ready <= 1'b1;
                        state        <= ST_READY;
                    end
                end
                // Table is full, inserts stay refused until reset
                ST_FULL:   state <= ST_FULL;
                default:   state <= ST_INIT;
            endcase
        end
    end

    // Carried entry, status and stash contents
    always_ff @(posedge clk) begin
        if (state == ST_READY && insert_req) begin
            carry_key   <= insert_key;
            carry_value <= insert_value;
        end else if (step_kick) begin
            carry_key   <= victim.key;
            carry_value <= victim.value;
        end
        if (state == ST_DECIDE) begin
            insert_status <= step_status;
        end
        if (step_stash) begin
            stash_key   <= carry_key;
            stash_value <= carry_value;
        end else if (stash_update) begin
            stash_value <= carry_value;
        end
    end

    assert property (@(posedge clk) disable iff (reset) insert_req |-> insert_ready)
        else $error("htable_cuckoo_ctrl: insert_req while not ready");

endmodule : htable_cuckoo_ctrl

`default_nettype wire

//--- rtl/htable_hash.sv
`default_nettype none

module htable_hash (
    input  logic              clk,
    input  htable_pkg::key_t  lookup_key,
    input  htable_pkg::key_t  ctrl_key,
    output htable_pkg::hash_t lookup_hash0,
    output htable_pkg::hash_t lookup_hash1,
    output htable_pkg::hash_t ctrl_hash0,
    output htable_pkg::hash_t ctrl_hash1
);
    import htable_pkg::*;

    // Table 0 index: fold the key halves, upper half rotated
    function automatic hash_t hash_fold(input key_t key);
        logic [7:0] folded;
        folded = key[7:0] ^ {key[12:8], key[15:13]};
        return folded[4:0] ^ {2'b00, folded[7:5]};
    endfunction

    // Table 1 index: top bits of a multiply by an odd constant
    function automatic hash_t hash_mult(input key_t key);
        key_t product;
        product = key * 16'h9e37;
        return product[$bits(key_t)-1 -: $bits(hash_t)];
    endfunction

    // Independent lookup and control channels
    always_ff @(posedge clk) begin
        lookup_hash0 <= hash_fold(lookup_key);
        lookup_hash1 <= hash_mult(lookup_key);
        ctrl_hash0   <= hash_fold(ctrl_key);
        ctrl_hash1   <= hash_mult(ctrl_key);
    end

endmodule : htable_hash

`default_nettype wire

//--- rtl/htable_lookup.sv
`default_nettype none

module htable_lookup (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   lookup_req,
    input  htable_pkg::key_t       lookup_key,
    input  logic                   init_done,
    input  htable_pkg::tbl_entry_t bank0_data,
    input  htable_pkg::tbl_entry_t bank1_data,
    input  logic                   stash_valid,
    input  htable_pkg::key_t       stash_key,
    input  htable_pkg::value_t     stash_value,
    output logic                   lookup_ack,
    output logic                   lookup_hit,
    output htable_pkg::value_t     lookup_value
);
    import htable_pkg::*;

    logic   s1_valid;
    logic   s2_valid;
    key_t   s1_key;
    key_t   s2_key;
    logic   hit0;
    logic   hit1;
    logic   hit_stash;
    value_t hit_value;

    // Stage 1 lines up with the hash, stage 2 with the bank read
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            lookup_ack <= 1'b0;
            lookup_hit <= 1'b0;
        end else begin
            s1_valid   <= lookup_req && init_done;
            s2_valid   <= s1_valid;
            lookup_ack <= s2_valid;
            lookup_hit <= s2_valid && (hit0 || hit1 || hit_stash);
        end
    end

    always_ff @(posedge clk) begin
        s1_key       <= lookup_key;
        s2_key       <= s1_key;
        lookup_value <= hit_value;
    end

    // --------------------
    // Compare
    // --------------------
    assign hit0      = bank0_data.valid && (bank0_data.key == s2_key);
    assign hit1      = bank1_data.valid && (bank1_data.key == s2_key);
    assign hit_stash = stash_valid && (stash_key == s2_key);

    // Zero on a miss
    always_comb begin
        hit_value = '0;
        if (hit0) begin
            hit_value = bank0_data.value;
        end else if (hit1) begin
            hit_value = bank1_data.value;
        end else if (hit_stash) begin
            hit_value = stash_value;
        end
    end

    // A key lives in one place only
    assert property (@(posedge clk) disable iff (reset)
        s2_valid |-> $onehot0({hit0, hit1, hit_stash}))
        else $error("htable_lookup: key found in more than one place");

endmodule : htable_lookup

`default_nettype wire

//--- rtl/htable_pkg.sv
`include "htable_settings.svh"
`default_nettype none

package htable_pkg;

    // --------------------
    // Basic fields
    // --------------------
    typedef logic [`HTABLE_KEY_WIDTH-1:0]   key_t;
    typedef logic [`HTABLE_VALUE_WIDTH-1:0] value_t;
    typedef logic [`HTABLE_ADDR_WIDTH-1:0]  hash_t;

    // One table slot
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } tbl_entry_t;

    // Insert outcome reported with insert_done
    typedef enum logic [1:0] {
        INSERT_ADDED   = 2'd0,
        INSERT_UPDATED = 2'd1,
        INSERT_STASHED = 2'd2
    } insert_status_t;

endpackage : htable_pkg

`default_nettype wire

//--- rtl/htable_settings.svh
`ifndef HTABLE_SETTINGS_SVH
`define HTABLE_SETTINGS_SVH

// --------------------
// Entry fields
// --------------------
`define HTABLE_KEY_WIDTH   16
`define HTABLE_VALUE_WIDTH 16

// --------------------
// Table geometry
// --------------------
// 32 slots per bank
`define HTABLE_ADDR_WIDTH  5

// Displacements per insert before falling back to the stash
`define HTABLE_MAX_KICKS   8

`endif

//--- sources.f
+incdir+rtl
rtl/htable_pkg.sv
rtl/htable_bank_intf.sv
rtl/htable_hash.sv
rtl/htable_bank.sv
rtl/htable_lookup.sv
rtl/htable_cuckoo_ctrl.sv
rtl/htable_cuckoo_core.sv
verif/htable_cuckoo_tb.sv

//--- verif/htable_cuckoo_tb.sv
`default_nettype none

module htable_cuckoo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import htable_pkg::*;

    localparam int INIT_TIMEOUT  = 200;
    localparam int READY_TIMEOUT = 200;
    localparam int DONE_TIMEOUT  = 200;

    logic           clk;
    logic           reset;
    logic           init_done;
    logic           lookup_req;
    key_t           lookup_key;
    logic           lookup_ack;
    logic           lookup_hit;
    value_t         lookup_value;
    logic           insert_req;
    key_t           insert_key;
    value_t         insert_value;
    logic           insert_ready;
    logic           insert_done;
    insert_status_t insert_status;

    // Reference map and run state
    value_t model [key_t];
    key_t   probe_keys [$];
    integer seed;
    int     checks;
    int     errors;
    logic   stashed;
    logic   timed_out;

    htable_cuckoo_core htable_cuckoo_core_inst (
        .clk           (clk),
        .reset         (reset),
        .init_done     (init_done),
        .lookup_req    (lookup_req),
        .lookup_key    (lookup_key),
        .lookup_ack    (lookup_ack),
        .lookup_hit    (lookup_hit),
        .lookup_value  (lookup_value),
        .insert_req    (insert_req),
        .insert_key    (insert_key),
        .insert_value  (insert_value),
        .insert_ready  (insert_ready),
        .insert_done   (insert_done),
        .insert_status (insert_status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Run control
    // --------------------
    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic wait_insert_ready();
        int cnt;
        cnt = 0;
        while (!insert_ready && cnt < READY_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!insert_ready) begin
            report_timeout("insert_ready");
        end
    endtask

    // --------------------
    // Insert
    // --------------------
    task automatic insert_entry(input key_t key, input value_t value);
        int   cnt;
        logic existed;
        wait_insert_ready();
        if (!timed_out) begin
            existed = (model.exists(key) != 0);
            @(posedge clk);
            insert_req   <= 1'b1;
            insert_key   <= key;
            insert_value <= value;
            @(posedge clk);
            insert_req <= 1'b0;
            cnt = 0;
            @(negedge clk);
            while (!insert_done && cnt < DONE_TIMEOUT) begin
                @(negedge clk);
                cnt++;
            end
            if (!insert_done) begin
                report_timeout("insert_done");
            end else begin
                checks++;
                if (existed && insert_status != INSERT_UPDATED) begin
                    errors++;
                    $display("FAILED insert_status: key %h expected %h got %h",
                             key, INSERT_UPDATED, insert_status);
                end else if (!existed && insert_status != INSERT_ADDED
                             && insert_status != INSERT_STASHED) begin
                    errors++;
                    $display("FAILED insert_status: key %h expected %h or %h got %h",
                             key, INSERT_ADDED, INSERT_STASHED, insert_status);
                end
                model[key] = value;
                if (insert_status == INSERT_STASHED) begin
                    stashed = 1'b1;
                end else begin
                    // Ready again one cycle after the done pulse
                    @(negedge clk);
                    checks++;
                    if (!insert_ready) begin
                        errors++;
                        $display("insert_ready did not return after insert of key %h", key);
                    end
                end
            end
        end
    endtask

    // --------------------
    // Lookup
    // --------------------
    task automatic compare_lookup(input key_t key);
        logic   exp_hit;
        value_t exp_value;
        exp_hit   = (model.exists(key) != 0);
        exp_value = '0;
        if (exp_hit) begin
            exp_value = model[key];
        end
        checks++;
        if (!lookup_ack) begin
            errors++;
            $display("no lookup_ack three cycles after request for key %h", key);
        end else begin
            if (lookup_hit !== exp_hit) begin
                errors++;
                $display("FAILED lookup_hit: key %h expected %h got %h",
                         key, exp_hit, lookup_hit);
            end
            if (lookup_value !== exp_value) begin
                errors++;
                $display("FAILED lookup_value: key %h expected %h got %h",
                         key, exp_value, lookup_value);
            end
        end
    endtask

    // One request per cycle and each answer due three cycles later
    task automatic run_lookups();
        int n;
        int c;
        n = probe_keys.size();
        fork
            begin
                foreach (probe_keys[i]) begin
                    @(posedge clk);
                    lookup_req <= 1'b1;
                    lookup_key <= probe_keys[i];
                end
                @(posedge clk);
                lookup_req <= 1'b0;
            end
            begin
                @(posedge clk);
                for (c = 0; c < n + 4; c++) begin
                    @(negedge clk);
                    if (c >= 3 && c < n + 3) begin
                        compare_lookup(probe_keys[c - 3]);
                    end else begin
                        checks++;
                        if (lookup_ack) begin
                            errors++;
                            $display("lookup_ack without a matching request");
                        end
                    end
                end
            end
        join
    endtask

    // Every stored key plus a few keys outside the stored range
    task automatic probe_all(input int misses);
        int          m;
        logic [31:0] rnd;
        probe_keys.delete();
        foreach (model[k]) begin
            probe_keys.push_back(k);
        end
        for (m = 0; m < misses; m++) begin
            rnd = $random(seed);
            probe_keys.push_back({4'hf, rnd[11:0]});
        end
        run_lookups();
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int          i;
        int          b;
        int          cnt;
        logic [31:0] rnd;
        key_t        next_key;
        seed         = 32'h110095bd;
        checks       = 0;
        errors       = 0;
        stashed      = 1'b0;
        timed_out    = 1'b0;
        reset        = 1'b1;
        lookup_req   = 1'b0;
        lookup_key   = '0;
        insert_req   = 1'b0;
        insert_key   = '0;
        insert_value = '0;

        repeat (4) @(posedge clk);
        reset      <= 1'b0;
        lookup_req <= 1'b1;
        lookup_key <= 16'h0003;

        // Requests during the init sweep are dropped
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            checks++;
            if (lookup_ack) begin
                errors++;
                $display("lookup_ack seen before init_done");
            end
        end
        @(posedge clk);
        lookup_req <= 1'b0;

        cnt = 0;
        while (!init_done && cnt < INIT_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!init_done) begin
            report_timeout("init_done");
        end

        // Small key range so that updates happen
        for (b = 0; b < 4 && !stashed && !timed_out; b++) begin
            for (i = 0; i < 12 && !stashed && !timed_out; i++) begin
                rnd = $random(seed);
                insert_entry({11'd0, rnd[4:0]}, rnd[31:16]);
            end
            if (!timed_out) begin
                probe_all(6);
            end
        end

        // Distinct keys until the table overflows
        next_key = 16'h0100;
        i = 0;
        while (!stashed && !timed_out && i < 300) begin
            rnd = $random(seed);
            insert_entry(next_key, rnd[15:0]);
            next_key = next_key + 16'd1;
            i++;
        end
        if (!timed_out) begin
            checks++;
            if (!stashed) begin
                errors++;
                $display("no INSERT_STASHED after a long run of distinct keys");
            end else begin
                for (i = 0; i < 100; i++) begin
                    @(negedge clk);
                    checks++;
                    if (insert_ready) begin
                        errors++;
                        $display("insert_ready high after the stash was taken");
                    end
                end
            end
            probe_all(8);
        end
        finish_run();
    end

endmodule : htable_cuckoo_tb

`default_nettype wire
